/* src/conv_num_pkg.sv */
`default_nettype none

package conv_num_pkg;

  // pixels, weights and outputs share one signed byte format
  typedef logic signed [7:0] word_t;

  // wide enough for CIN_MAX products of two bytes with headroom
  typedef logic signed [23:0] acc_t;

  // accumulator to output scale
  localparam int OUT_SHIFT = 4;

  // alpha = 1/8 for negative values in leaky relu
  localparam int ALPHA_SHIFT = 3;

  // word limits in accumulator width for saturation
  localparam acc_t WORD_MAX = acc_t'((1 << ($bits(word_t) - 1)) - 1);
  localparam acc_t WORD_MIN = acc_t'(-(1 << ($bits(word_t) - 1)));

endpackage

`default_nettype wire

/* src/conv_stream_pkg.sv */
`default_nettype none

package conv_stream_pkg;

  // sideband of a pixel beat
  // last_cin is the tlast of the pixel stream
  typedef struct packed {
    logic last_cin;
    logic is_lrelu;
  } pix_user_t;

  // sideband of an accumulator beat, one per pixel group
  typedef struct packed {
    logic is_lrelu;
  } acc_user_t;

endpackage

`default_nettype wire

/* src/stream_reg.sv */
`default_nettype none

module stream_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,

  input  logic in_valid,
  output logic in_ready,
  input  T     in_payload,

  output logic out_valid,
  input  logic out_ready,
  output T     out_payload
);

  // held low through reset so the upstream never sees ready early
  logic live;

  assign in_ready = live && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      live <= 1'b1;
      if (in_ready) begin
        out_valid <= in_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_payload <= in_payload;
    end
  end

  // a waiting upstream beat must hold until it is taken
  in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_payload));

endmodule

`default_nettype wire

/* src/weights_bank.sv */
`default_nettype none

module weights_bank
  import conv_num_pkg::*;
#(
  parameter int CORES   = 2,
  parameter int CIN_MAX = 8,
  localparam int IDX_W  = (CIN_MAX > 1) ? $clog2(CIN_MAX) : 1,
  localparam int CNT_W  = $clog2(CIN_MAX + 1)
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  weights_valid,
  input  logic                  weights_last,
  input  word_t [CORES-1:0]     weights_data,
  output logic                  weights_ready,

  input  logic                  busy,
  input  logic [IDX_W-1:0]      cin_index,
  output logic                  loading,
  output logic [CNT_W-1:0]      cin_count,
  output word_t [CORES-1:0]     weight_row
);

  // one row per input channel, one weight per core
  word_t [CORES-1:0] rows [CIN_MAX];

  logic [CNT_W-1:0] wr_ptr;
  logic             live;
  logic             accept;

  // no reload while the engine is mid-group
  assign weights_ready = live && !busy;
  assign accept        = weights_valid && weights_ready;
  assign weight_row    = rows[cin_index];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live      <= 1'b0;
      loading   <= 1'b0;
      wr_ptr    <= '0;
      cin_count <= '0;
    end else begin
      live <= 1'b1;
      if (accept) begin
        if (weights_last) begin
          cin_count <= wr_ptr + 1'b1;
          wr_ptr    <= '0;
          loading   <= 1'b0;
        end else begin
          wr_ptr  <= wr_ptr + 1'b1;
          loading <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rows[IDX_W'(wr_ptr)] <= weights_data;
    end
  end

  row_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    weights_valid && weights_ready |-> wr_ptr < CNT_W'(CIN_MAX));

endmodule

`default_nettype wire

/* src/conv_engine.sv */
`default_nettype none

module conv_engine
  import conv_num_pkg::*;
  import conv_stream_pkg::*;
#(
  parameter int UNITS   = 4,
  parameter int CORES   = 2,
  parameter int CIN_MAX = 8,
  localparam int IDX_W  = (CIN_MAX > 1) ? $clog2(CIN_MAX) : 1,
  localparam int CNT_W  = $clog2(CIN_MAX + 1)
) (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [$bits(pix_user_t)+UNITS*$bits(word_t)-1:0] in_payload,

  input  logic                           loading,
  input  logic [CNT_W-1:0]               cin_count,
  input  word_t [CORES-1:0]              weight_row,
  output logic [IDX_W-1:0]               cin_index,
  output logic                           busy,

  output logic                           acc_valid,
  input  logic                           acc_ready,
  output acc_t [CORES-1:0][UNITS-1:0]    acc_data,
  output acc_user_t                      acc_user
);

  // same layout as the pixel beat built at the top level
  typedef struct packed {
    pix_user_t          user;
    word_t [UNITS-1:0]  data;
  } pix_beat_t;

  pix_beat_t                    beat;
  acc_t [CORES-1:0][UNITS-1:0]  sum;
  acc_t [CORES-1:0][UNITS-1:0]  next_sum;
  logic                         first;
  logic                         take;

  assign beat     = pix_beat_t'(in_payload);
  assign in_ready = !loading && (!acc_valid || acc_ready);
  assign take     = in_valid && in_ready;
  assign first    = (cin_index == '0);

  // a waiting pixel beat also counts, so weights cannot slip in under it
  assign busy = !first || (in_valid && !loading);

  // mac array, restarting from zero on channel 0
  always_comb begin
    for (int k = 0; k < CORES; k++) begin
      for (int u = 0; u < UNITS; u++) begin
        next_sum[k][u] = (first ? acc_t'(0) : sum[k][u])
                       + acc_t'(beat.data[u]) * acc_t'(weight_row[k]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cin_index <= '0;
      acc_valid <= 1'b0;
    end else begin
      if (acc_valid && acc_ready) begin
        acc_valid <= 1'b0;
      end
      if (take) begin
        if (beat.user.last_cin) begin
          cin_index <= '0;
          acc_valid <= 1'b1;
        end else begin
          cin_index <= cin_index + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sum <= next_sum;
      if (beat.user.last_cin) begin
        acc_data <= next_sum;
        acc_user <= '{is_lrelu: beat.user.is_lrelu};
      end
    end
  end

  // pixel tlast has to agree with the loaded channel count
  last_at_count: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> beat.user.last_cin == (CNT_W'(cin_index) == cin_count - 1'b1));

endmodule

`default_nettype wire

/* src/lrelu_engine.sv */
`default_nettype none

module lrelu_engine
  import conv_num_pkg::*;
  import conv_stream_pkg::*;
#(
  parameter int UNITS = 4,
  parameter int CORES = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          acc_valid,
  output logic                          acc_ready,
  input  acc_t [CORES-1:0][UNITS-1:0]   acc_data,
  input  acc_user_t                     acc_user,

  output logic                          out_valid,
  input  logic                          out_ready,
  output word_t [CORES-1:0][UNITS-1:0]  out_data
);

  word_t [CORES-1:0][UNITS-1:0] result;

  function automatic word_t clip(acc_t v);
    if (v > WORD_MAX) begin
      return word_t'(WORD_MAX);
    end
    if (v < WORD_MIN) begin
      return word_t'(WORD_MIN);
    end
    return word_t'(v);
  endfunction

  // rescale, then negative side scaled by alpha when flagged
  always_comb begin
    acc_t y;
    for (int k = 0; k < CORES; k++) begin
      for (int u = 0; u < UNITS; u++) begin
        y = acc_data[k][u] >>> OUT_SHIFT;
        if (acc_user.is_lrelu && y < 0) begin
          y = y >>> ALPHA_SHIFT;
        end
        result[k][u] = clip(y);
      end
    end
  end

  assign acc_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (acc_ready) begin
      out_valid <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid && acc_ready) begin
      out_data <= result;
    end
  end

endmodule

`default_nettype wire

/* src/conv_accel_top.sv */
`default_nettype none

module conv_accel_top
  import conv_num_pkg::*;
  import conv_stream_pkg::*;
#(
  parameter int UNITS   = 4,
  parameter int CORES   = 2,
  parameter int CIN_MAX = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          weights_valid,
  input  logic                          weights_last,
  input  word_t [CORES-1:0]             weights_data,
  output logic                          weights_ready,

  input  logic                          pix_valid,
  input  logic                          pix_last,
  input  logic                          pix_lrelu,
  input  word_t [UNITS-1:0]             pix_data,
  output logic                          pix_ready,

  input  logic                          out_ready,
  output logic                          out_valid,
  output word_t [CORES-1:0][UNITS-1:0]  out_data
);

  localparam int IDX_W = (CIN_MAX > 1) ? $clog2(CIN_MAX) : 1;
  localparam int CNT_W = $clog2(CIN_MAX + 1);

  typedef struct packed {
    pix_user_t          user;
    word_t [UNITS-1:0]  data;
  } pix_beat_t;

  // core-major output beat
  typedef word_t [CORES-1:0][UNITS-1:0] out_beat_t;

  pix_beat_t                    pix_in;
  pix_beat_t                    eng_pix;
  logic                         eng_valid;
  logic                         eng_ready;

  logic                         loading;
  logic                         busy;
  logic [IDX_W-1:0]             cin_index;
  logic [CNT_W-1:0]             cin_count;
  word_t [CORES-1:0]            weight_row;

  logic                         acc_valid;
  logic                         acc_ready;
  acc_t [CORES-1:0][UNITS-1:0]  acc_data;
  acc_user_t                    acc_user;

  logic                         lr_valid;
  logic                         lr_ready;
  out_beat_t                    lr_data;

  assign pix_in = '{user: '{last_cin: pix_last, is_lrelu: pix_lrelu}, data: pix_data};

  stream_reg #(
    .T (pix_beat_t)
  ) pix_slice (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (pix_valid),
    .in_ready    (pix_ready),
    .in_payload  (pix_in),
    .out_valid   (eng_valid),
    .out_ready   (eng_ready),
    .out_payload (eng_pix)
  );

  weights_bank #(
    .CORES   (CORES),
    .CIN_MAX (CIN_MAX)
  ) bank (
    .clk           (clk),
    .rst_n         (rst_n),
    .weights_valid (weights_valid),
    .weights_last  (weights_last),
    .weights_data  (weights_data),
    .weights_ready (weights_ready),
    .busy          (busy),
    .cin_index     (cin_index),
    .loading       (loading),
    .cin_count     (cin_count),
    .weight_row    (weight_row)
  );

  conv_engine #(
    .UNITS   (UNITS),
    .CORES   (CORES),
    .CIN_MAX (CIN_MAX)
  ) engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (eng_valid),
    .in_ready   (eng_ready),
    .in_payload (eng_pix),
    .loading    (loading),
    .cin_count  (cin_count),
    .weight_row (weight_row),
    .cin_index  (cin_index),
    .busy       (busy),
    .acc_valid  (acc_valid),
    .acc_ready  (acc_ready),
    .acc_data   (acc_data),
    .acc_user   (acc_user)
  );

  lrelu_engine #(
    .UNITS (UNITS),
    .CORES (CORES)
  ) lrelu (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready),
    .acc_data  (acc_data),
    .acc_user  (acc_user),
    .out_valid (lr_valid),
    .out_ready (lr_ready),
    .out_data  (lr_data)
  );

  stream_reg #(
    .T (out_beat_t)
  ) out_slice (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (lr_valid),
    .in_ready    (lr_ready),
    .in_payload  (lr_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_payload (out_data)
  );

endmodule

`default_nettype wire

/* verification/conv_accel_tb.sv */
`default_nettype none

module conv_accel_tb
  import conv_num_pkg::*;
();

  localparam int UNITS   = 4;
  localparam int CORES   = 2;
  localparam int CIN_MAX = 8;
  localparam int TIMEOUT = 200;

  typedef word_t [CORES-1:0][UNITS-1:0] out_beat_t;

  // one weight or pixel beat from the stimulus file
  typedef struct packed {
    logic              is_pix;
    logic              last;
    logic              lrelu;
    word_t [CORES-1:0] wdata;
    word_t [UNITS-1:0] pdata;
  } op_t;

  logic              clk;
  logic              rst_n;
  logic              weights_valid;
  logic              weights_last;
  word_t [CORES-1:0] weights_data;
  logic              weights_ready;
  logic              pix_valid;
  logic              pix_last;
  logic              pix_lrelu;
  word_t [UNITS-1:0] pix_data;
  logic              pix_ready;
  logic              out_ready;
  logic              out_valid;
  out_beat_t         out_data;

  op_t       ops[$];
  out_beat_t exp_q[$];
  out_beat_t exp_beat;
  int        groups_in = 0;
  int        groups_out = 0;
  int        max_in_flight = 0;

  conv_accel_top #(
    .UNITS   (UNITS),
    .CORES   (CORES),
    .CIN_MAX (CIN_MAX)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .weights_valid (weights_valid),
    .weights_last  (weights_last),
    .weights_data  (weights_data),
    .weights_ready (weights_ready),
    .pix_valid     (pix_valid),
    .pix_last      (pix_last),
    .pix_lrelu     (pix_lrelu),
    .pix_data      (pix_data),
    .pix_ready     (pix_ready),
    .out_ready     (out_ready),
    .out_valid     (out_valid),
    .out_data      (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("** Error %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic check_out(input out_beat_t expected, input out_beat_t actual, input int beat);
    for (int k = 0; k < CORES; k++) begin
      for (int u = 0; u < UNITS; u++) begin
        if (actual[k][u] !== expected[k][u]) begin
          stop_with_error($sformatf("** Error out_data[%0d][%0d] beat %0d: expected %h, got %h",
                                    k, u, beat, expected[k][u], actual[k][u]));
        end
      end
    end
  endtask

  task automatic read_field(input int fd, output logic [7:0] v);
    if ($fscanf(fd, "%h", v) != 1) begin
      stop_with_error("malformed record in the stimulus file");
    end
  endtask

  task automatic load_stimulus();
    int               fd;
    int               code;
    logic [7:0]       tag;
    logic [7:0]       v;
    logic [8*128-1:0] line;
    op_t              op;
    out_beat_t        beat;
    fd = $fopen("verification/conv_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open verification/conv_stimulus.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code == 1) begin
        op = '0;
        if (tag == "#") begin
          code = $fgets(line, fd);
        end else if (tag == "W") begin
          read_field(fd, v);
          op.last = v[0];
          for (int k = 0; k < CORES; k++) begin
            read_field(fd, v);
            op.wdata[k] = word_t'(v);
          end
          ops.push_back(op);
        end else if (tag == "P") begin
          op.is_pix = 1'b1;
          read_field(fd, v);
          op.last = v[0];
          read_field(fd, v);
          op.lrelu = v[0];
          for (int u = 0; u < UNITS; u++) begin
            read_field(fd, v);
            op.pdata[u] = word_t'(v);
          end
          ops.push_back(op);
        end else if (tag == "E") begin
          // core-major, as on out_data
          for (int k = 0; k < CORES; k++) begin
            for (int u = 0; u < UNITS; u++) begin
              read_field(fd, v);
              beat[k][u] = word_t'(v);
            end
          end
          exp_q.push_back(beat);
        end else begin
          stop_with_error("unknown record tag in the stimulus file");
        end
      end
    end
    $fclose(fd);
    if (ops.size() == 0 || exp_q.size() == 0) begin
      stop_with_error("stimulus file holds no beats");
    end
  endtask

  // called 1 unit after a rising edge, returns 1 unit after the transfer edge
  task automatic send_weights(input op_t op);
    int n;
    weights_valid = 1'b1;
    weights_last  = op.last;
    weights_data  = op.wdata;
    n = 0;
    @(negedge clk);
    while (!weights_ready) begin
      n++;
      if (n > TIMEOUT) begin
        stop_with_error("weights_ready stayed low, weight beat never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    weights_valid = 1'b0;
  endtask

  task automatic send_pix(input op_t op);
    int n;
    pix_valid = 1'b1;
    pix_last  = op.last;
    pix_lrelu = op.lrelu;
    pix_data  = op.pdata;
    n = 0;
    @(negedge clk);
    while (!pix_ready) begin
      n++;
      if (n > TIMEOUT) begin
        stop_with_error("pix_ready stayed low, pixel beat never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
  endtask

  // random back-pressure on the output stream
  initial begin
    logic [31:0] state;
    state     = 32'd61288;
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      state     = lcg_next(state);
      out_ready = rst_n && (state[31:30] != 2'b00);
    end
  end

  // sampled mid-cycle, so these are the values seen at the next edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid && groups_in == groups_out) begin
        stop_with_error("out_valid high with no pixel group in flight");
      end
      if (pix_valid && pix_ready && pix_last) begin
        groups_in++;
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_error("output beat beyond the expected ones");
        end
        exp_beat = exp_q.pop_front();
        check_out(exp_beat, out_data, groups_out);
        groups_out++;
      end
      if (groups_in - groups_out > max_in_flight) begin
        max_in_flight = groups_in - groups_out;
      end
    end
  end

  initial begin
    op_t op;
    int  n;
    rst_n         = 1'b0;
    weights_valid = 1'b0;
    weights_last  = 1'b0;
    weights_data  = '0;
    pix_valid     = 1'b0;
    pix_last      = 1'b0;
    pix_lrelu     = 1'b0;
    pix_data      = '0;
    load_stimulus();
    repeat (16) @(posedge clk);
    #1;
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("pix_ready", 1'b0, pix_ready);
    check_flag("weights_ready", 1'b0, weights_ready);
    rst_n = 1'b1;
    while (ops.size() > 0) begin
      op = ops.pop_front();
      if (op.is_pix) begin
        send_pix(op);
      end else begin
        send_weights(op);
      end
    end
    n = 0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        stop_with_error("timeout waiting for the remaining output beats");
      end
    end
    // quiet window to catch a repeated beat
    repeat (20) @(posedge clk);
    if (max_in_flight < 2) begin
      stop_with_error("pipeline never held more than one pixel group");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/conv_stimulus.txt */
# W last core0 core1 | P last lrelu unit0..unit3 | E core0 unit0..3 then core1 unit0..3
# all fields hex, words are signed bytes
# one channel, positive results, groups back to back
W 1 03 05
P 1 0 10 20 30 40
E 03 06 09 0c 05 0a 0f 14
P 1 0 01 11 7f 64
E 00 03 17 12 00 05 27 1f
P 1 0 08 50 22 2d
E 01 0f 06 08 02 19 0a 0e
# three channels, mixed signs, leaky relu on the first group only
W 0 14 e7
W 0 f6 1e
W 1 0f 08
P 0 1 0a ec 1e 07
P 0 1 05 28 f1 f8
P 1 1 fa 09 0c 14
E 03 fa 3a 20 fe 6e f7 fe
P 0 0 f0 e0 d0 c0
P 0 0 f0 e0 d0 c0
P 1 0 f0 e0 d0 c0
E e7 ce b5 9c f3 e6 d9 cc
# two channels, large products saturate
W 0 7f 80
W 1 7f 80
P 0 0 7f 80 01 c0
P 1 0 7f 80 00 40
E 7f 80 07 00 80 7f f8 00
# one channel again, leaky relu
W 1 ff 02
P 1 1 40 c0 10 f0
E ff 04 ff 01 08 ff 02 ff
P 1 1 7f 80 00 c8
E ff 08 00 03 0f fe 00 ff

/* sim.f */
src/conv_num_pkg.sv
src/conv_stream_pkg.sv
src/stream_reg.sv
src/weights_bank.sv
src/conv_engine.sv
src/lrelu_engine.sv
src/conv_accel_top.sv
verification/conv_accel_tb.sv

/* Makefile */
TOP = conv_accel_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
